//--- source/i2c_seq_pkg.sv
/*
 * Shared types and widths for the table-driven i2c register-write sequencer.
 * The rtl and the testbench refer to these by scoped name.
 */
package i2c_seq_pkg;

    localparam int TD_W     = 28; // table load data width, one full entry
    localparam int SEQ_RA_W = 2;  // byte address inside the 4-byte command word

    typedef logic [7:0] byte_t;   // one i2c or sequencer memory byte
    typedef logic [7:0] dly_t;    // quarter bit length minus one, in mclk cycles

    // translation table entry, selected by byte 3 of a command word
    typedef struct packed {
        dly_t       dly;  // [27:20] quarter period minus one
        logic [3:0] nbwr; // [19:16] bytes sent after the slave address, 1..4
        logic [6:0] sa;   // [15:9] 7-bit slave address
        logic       rsvd; // [8] old read flag, ignored
        byte_t      rah;  // [7:0] register address high byte
    } tbl_entry_t;

    // nbwr of 4 sends rah then bytes 2..0
    // nbwr of 3 or less sends the low nbwr bytes of the word only
    // dly of 0 gives a 4 cycle bit, the fastest the engine runs

endpackage

//--- source/i2c_bit_if.sv
/*
 * Command and status lines between the command sequencer and the bit engine.
 * The sequencer raises one snd level and holds it with din until ready is
 * seen, the engine then runs the command with ready low.
 */
interface i2c_bit_if;

    logic                 snd_start; // request a start condition
    logic                 snd_stop;  // request a stop condition
    logic                 snd9;      // request a 9-bit frame from din
    logic [8:0]           din;       // byte msb first, then the released ack bit
    i2c_seq_pkg::dly_t    dly;       // quarter length used by the next command
    logic                 ready;     // engine idle, takes a snd level this cycle
    logic                 bus_busy;  // a command is running on the bus
    logic                 bus_open;  // start sent, stop not yet sent

    modport seq (
        output snd_start, snd_stop, snd9, din, dly,
        input  ready, bus_busy, bus_open
    );

    modport eng (
        input  snd_start, snd_stop, snd9, din, dly,
        output ready, bus_busy, bus_open
    );

endinterface

//--- source/i2c_xlat_table.sv
/*
 * Translation table for command byte 3.
 * Loading: a twe with tand high sets the write address, each later twe with
 * tand low stores td as one entry and bumps the address.
 * Reading: rd_en with rd_addr, entry is valid two cycles later
 * (ram read then output register, like a block ram with regen).
 */
module i2c_xlat_table #(
    parameter int TBL_ADDR_BITS = 8
) (
    input  logic                         mclk,
    input  logic                         mrst,
    input  logic                         tand,    // td carries an address
    input  logic [i2c_seq_pkg::TD_W-1:0] td,
    input  logic                         twe,
    input  i2c_seq_pkg::byte_t           rd_addr, // low TBL_ADDR_BITS bits used
    input  logic                         rd_en,
    output i2c_seq_pkg::tbl_entry_t      entry
);

    localparam int DEPTH = 1 << TBL_ADDR_BITS;

    logic [TBL_ADDR_BITS-1:0] twa;        // write address
    i2c_seq_pkg::tbl_entry_t  mem [DEPTH];
    i2c_seq_pkg::tbl_entry_t  rd_q;       // first read stage
    logic                     regen;      // output register enable

    // write address, loaded by tand, advanced after every data write
    always_ff @(posedge mclk) begin
        if (mrst) begin
            twa <= '0;
        end else if (twe) begin
            twa <= tand ? td[TBL_ADDR_BITS-1:0] : twa + 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (twe && !tand) mem[twa] <= td; // entry layout matches td bit for bit
    end

    always_ff @(posedge mclk) begin
        if (mrst) regen <= 1'b0;
        else regen <= rd_en;              // second stage follows one cycle later
    end

    always_ff @(posedge mclk) begin
        if (rd_en) rd_q <= mem[rd_addr[TBL_ADDR_BITS-1:0]];
        if (regen) entry <= rd_q;         // held until the next read
    end

endmodule

//--- source/i2c_cmd_seq.sv
/*
 * Write command sequencer.
 * i2c_start fetches byte 3 of the command word, which indexes the table.
 * The table entry then drives a one-hot stage chain: start, slave address,
 * optional high byte, data bytes 2..0 from sequencer memory, stop.
 * Each stage hands one command to the bit engine over i2c_bit_if.
 */
module i2c_cmd_seq (
    input  logic                             mclk,
    input  logic                             mrst,
    input  logic                             i2c_rst,    // synchronous abort
    input  logic                             i2c_start,  // pulse, only while not busy
    output logic [i2c_seq_pkg::SEQ_RA_W-1:0] seq_mem_ra, // byte number in the word
    output logic [1:0]                       seq_mem_re, // [0] re, [1] regen
    input  i2c_seq_pkg::byte_t               seq_rd,     // valid after seq_mem_re[1]
    output logic                             tbl_rd,
    output i2c_seq_pkg::byte_t               tbl_addr,
    input  i2c_seq_pkg::tbl_entry_t          entry,
    i2c_bit_if.seq                           bif,
    output logic                             i2c_run,    // low once stop is handed over
    output logic                             i2c_busy    // low once the bus is idle
);

    logic                    clr;          // reset or abort
    logic [6:0]              stg;          // [6] start [5] sa [4] rah [3:1] byte 2..0 [0] stop
    i2c_seq_pkg::tbl_entry_t ent_q;        // entry of the running command
    i2c_seq_pkg::byte_t      data_q;       // last byte from sequencer memory
    logic [2:0]              mem_re;       // re, regen, data valid
    logic                    first_mem_re; // fetch in flight is byte 3
    logic                    mem_valid;    // data_q belongs to the current stage
    logic [1:0]              tbl_pipe;     // table read latency
    logic                    start_seq;    // entry valid, start the chain
    logic                    pre_next_cmd; // engine takes a command this cycle
    logic                    next_cmd;     // first cycle after acceptance
    logic                    next_cmd_d;   // first cycle in the new stage
    logic                    data_stg;
    logic                    want_snd9;
    logic                    run_any_d;
    logic                    pre_cmd;      // covers the byte 3 and table fetch

    assign clr          = mrst | i2c_rst;
    assign start_seq    = tbl_pipe[1];
    assign data_stg     = |stg[3:1];
    assign pre_next_cmd = (bif.snd_start | bif.snd_stop | bif.snd9) & bif.ready;
    assign want_snd9    = (|stg[5:4]) | (data_stg & mem_valid); // data waits for memory
    assign seq_mem_re   = mem_re[1:0];
    assign bif.dly      = ent_q.dly;

    // stage chain, the stage after sa follows nbwr
    always_ff @(posedge mclk) begin
        if (clr) begin
            stg <= '0;
        end else if (start_seq) begin
            stg <= 7'h40;
        end else if (next_cmd) begin
            stg <= {1'b0,
                    stg[6],                                    // sa after start
                    stg[5] & (ent_q.nbwr >= 4'd4),             // high byte from table
                    stg[4] | (stg[5] & (ent_q.nbwr == 4'd3)),  // byte 2
                    stg[3] | (stg[5] & (ent_q.nbwr == 4'd2)),  // byte 1
                    stg[2] | (stg[5] & (ent_q.nbwr == 4'd1)),  // byte 0
                    stg[1] | (stg[5] & (ent_q.nbwr == 4'd0))}; // empty entry stops
        end
    end

    // sequencer memory fetches and the table read
    always_ff @(posedge mclk) begin
        if (clr) begin
            mem_re       <= '0;
            first_mem_re <= 1'b0;
            mem_valid    <= 1'b0;
            tbl_rd       <= 1'b0;
            tbl_pipe     <= '0;
        end else begin
            mem_re <= {mem_re[1:0], i2c_start | (next_cmd_d & data_stg)};
            if (i2c_start) first_mem_re <= 1'b1;
            else if (mem_re[2]) first_mem_re <= 1'b0;
            if (i2c_start || next_cmd) mem_valid <= 1'b0;
            else if (mem_re[2]) mem_valid <= 1'b1;
            tbl_rd   <= first_mem_re & mem_re[2];   // one cycle after byte 3 arrives
            tbl_pipe <= {tbl_pipe[0], tbl_rd};
        end
    end

    always_ff @(posedge mclk) begin
        seq_mem_ra <= i2c_start ? '1 : {stg[3], stg[2]}; // byte 3 first, then 2, 1, 0
        if (mem_re[2]) data_q <= seq_rd;
        if (first_mem_re && mem_re[2]) tbl_addr <= seq_rd;
        if (start_seq) ent_q <= entry;
    end

    // snd levels held until ready, dropped in the next_cmd cycle
    always_ff @(posedge mclk) begin
        if (clr) begin
            next_cmd      <= 1'b0;
            next_cmd_d    <= 1'b0;
            bif.snd_start <= 1'b0;
            bif.snd_stop  <= 1'b0;
            bif.snd9      <= 1'b0;
        end else begin
            next_cmd   <= pre_next_cmd;
            next_cmd_d <= next_cmd;
            if (next_cmd) begin
                bif.snd_start <= 1'b0;
                bif.snd_stop  <= 1'b0;
                bif.snd9      <= 1'b0;
            end else begin
                bif.snd_start <= bif.snd_start ? !bif.ready : stg[6];
                bif.snd_stop  <= bif.snd_stop ? !bif.ready : stg[0];
                bif.snd9      <= bif.snd9 ? !bif.ready : want_snd9;
            end
        end
    end

    // shift data source, stable while a stage lasts
    always_comb begin
        if (stg[5]) bif.din = {ent_q.sa, 1'b0, 1'b1};  // write address
        else if (stg[4]) bif.din = {ent_q.rah, 1'b1};
        else bif.din = {data_q, 1'b1};
    end

    always_ff @(posedge mclk) begin
        if (clr) begin
            run_any_d <= 1'b0;
            pre_cmd   <= 1'b0;
            i2c_run   <= 1'b0;
            i2c_busy  <= 1'b0;
        end else begin
            run_any_d <= |stg;
            if (i2c_start) pre_cmd <= 1'b1;
            else if (run_any_d) pre_cmd <= 1'b0;
            i2c_run  <= i2c_start | pre_cmd | run_any_d;
            i2c_busy <= i2c_start | pre_cmd | run_any_d | bif.bus_busy | bif.bus_open;
        end
    end

    // a new command only starts after the previous one has left the chain
    a_start_idle: assert property (@(posedge mclk) disable iff (clr)
        i2c_start |-> !i2c_run);

endmodule

//--- source/i2c_bit_engine.sv
/*
 * SCL and SDA generator for start, stop and 9-bit byte frames.
 * Every quarter lasts dly+1 mclk cycles, dly is taken with the command.
 * A byte bit has scl low in quarters 0,1 and high in 2,3, sda moves at
 * quarter 0 only. sda_en high pulls the open-drain SDA line low.
 */
module i2c_bit_engine (
    input  logic   mclk,
    input  logic   mrst,
    input  logic   i2c_rst, // abort, bus returns to idle levels
    i2c_bit_if.eng bif,
    output logic   scl,
    output logic   sda_en
);

    typedef enum logic [1:0] {M_IDLE, M_START, M_STOP, M_BYTE} mode_t;

    mode_t             mode;
    i2c_seq_pkg::dly_t qtmr;   // cycles left in this quarter
    i2c_seq_pkg::dly_t dly_q;  // quarter reload for the running command
    logic [1:0]        qcnt;   // quarter within the bit or condition
    logic [3:0]        bcnt;   // bit within the frame, 8 is ack
    logic [7:0]        sr;     // shift register, sr[7] goes out at the next bit
    logic              accept;
    logic              q_end;

    assign accept       = bif.ready & (bif.snd_start | bif.snd_stop | bif.snd9);
    assign q_end        = (qtmr == '0);
    assign bif.ready    = (mode == M_IDLE);
    assign bif.bus_busy = (mode != M_IDLE);

    always_ff @(posedge mclk) begin
        if (mrst || i2c_rst) begin
            mode         <= M_IDLE;
            qtmr         <= '0;
            qcnt         <= '0;
            bcnt         <= '0;
            scl          <= 1'b1;
            sda_en       <= 1'b0;
            bif.bus_open <= 1'b0;
        end else if (mode == M_IDLE) begin
            if (accept) begin
                qtmr <= bif.dly;
                qcnt <= '0;
                bcnt <= '0;
                if (bif.snd_start) begin
                    mode   <= M_START;
                    scl    <= 1'b1;          // sda released, scl high
                    sda_en <= 1'b0;
                end else if (bif.snd_stop) begin
                    mode   <= M_STOP;
                    scl    <= 1'b0;
                    sda_en <= 1'b1;          // sda low while scl is low
                end else begin
                    mode   <= M_BYTE;
                    scl    <= 1'b0;
                    sda_en <= !bif.din[8];   // first bit
                end
            end
        end else if (!q_end) begin
            qtmr <= qtmr - 1'b1;
        end else begin
            qtmr <= dly_q;
            qcnt <= qcnt + 1'b1;
            case (mode)
                M_START: begin
                    if (qcnt == 2'd0) begin
                        sda_en <= 1'b1;          // sda falls with scl high
                    end else if (qcnt == 2'd1) begin
                        scl <= 1'b0;
                    end else begin
                        mode         <= M_IDLE;
                        bif.bus_open <= 1'b1;
                    end
                end
                M_STOP: begin
                    if (qcnt == 2'd0) begin
                        scl <= 1'b1;
                    end else if (qcnt == 2'd1) begin
                        sda_en <= 1'b0;          // sda rises with scl high
                    end else begin
                        mode         <= M_IDLE;
                        bif.bus_open <= 1'b0;
                    end
                end
                default: begin
                    if (qcnt == 2'd1) begin
                        scl <= 1'b1;
                    end else if (qcnt == 2'd3) begin
                        scl <= 1'b0;             // idle gap keeps scl low
                        if (bcnt == 4'd8) begin
                            mode <= M_IDLE;
                        end else begin
                            bcnt   <= bcnt + 1'b1;
                            sda_en <= (bcnt == 4'd7) ? 1'b0 : !sr[7]; // ack released
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (accept) begin
            sr    <= bif.din[7:0];   // din[8] is already on the line
            dly_q <= bif.dly;
        end else if (mode == M_BYTE && q_end && qcnt == 2'd3) begin
            sr <= {sr[6:0], 1'b1};
        end
    end

    a_one_snd: assert property (@(posedge mclk) disable iff (mrst || i2c_rst)
        $onehot0({bif.snd_start, bif.snd_stop, bif.snd9}));

    // sequencer keeps the frame data still while the engine is busy
    a_din_hold: assert property (@(posedge mclk) disable iff (mrst || i2c_rst)
        bif.snd9 && !bif.ready |=> $stable(bif.din));

endmodule

//--- source/i2c_seq_top.sv
/*
 * Top level of the i2c register-write sequencer.
 * Wires the translation table, the command sequencer and the bit engine.
 * Load the table through tand/td/twe, then pulse i2c_start per command word.
 */
module i2c_seq_top #(
    parameter int TBL_ADDR_BITS = 8
) (
    input  logic                             mclk,
    input  logic                             mrst,
    input  logic                             i2c_rst,
    input  logic                             i2c_start,
    input  logic                             tand,
    input  logic [i2c_seq_pkg::TD_W-1:0]     td,
    input  logic                             twe,
    output logic [i2c_seq_pkg::SEQ_RA_W-1:0] seq_mem_ra,
    output logic [1:0]                       seq_mem_re,
    input  i2c_seq_pkg::byte_t               seq_rd,
    output logic                             scl,
    output logic                             sda_en,
    output logic                             i2c_run,
    output logic                             i2c_busy
);

    logic                    tbl_rd;
    i2c_seq_pkg::byte_t      tbl_addr;
    i2c_seq_pkg::tbl_entry_t entry;

    i2c_bit_if bif ();

    i2c_xlat_table #(
        .TBL_ADDR_BITS (TBL_ADDR_BITS)
    ) i_table (
        .mclk (mclk), .mrst (mrst), .tand (tand), .td (td), .twe (twe),
        .rd_addr (tbl_addr), .rd_en (tbl_rd), .entry (entry)
    );

    i2c_cmd_seq i_seq (
        .mclk (mclk), .mrst (mrst), .i2c_rst (i2c_rst), .i2c_start (i2c_start),
        .seq_mem_ra (seq_mem_ra), .seq_mem_re (seq_mem_re), .seq_rd (seq_rd),
        .tbl_rd (tbl_rd), .tbl_addr (tbl_addr), .entry (entry), .bif (bif.seq),
        .i2c_run (i2c_run), .i2c_busy (i2c_busy)
    );

    i2c_bit_engine i_eng (
        .mclk (mclk), .mrst (mrst), .i2c_rst (i2c_rst), .bif (bif.eng),
        .scl (scl), .sda_en (sda_en)
    );

endmodule

//--- verification/i2c_slave_mon.sv
/*
 * Passive i2c bus monitor for the sequencer testbench.
 * Samples scl and sda on mclk, reports start, byte and stop events and
 * the length of each scl phase inside a byte frame.
 * flush clears the decoder, held during reset and aborts.
 */
module i2c_slave_mon (
    input  logic               mclk,
    input  logic               flush,    // drop decoder state
    input  logic               scl,
    input  logic               sda,      // line level, low when driven
    output logic               ev_valid,
    output logic [1:0]         ev_kind,  // 0 start, 1 byte, 2 stop
    output i2c_seq_pkg::byte_t ev_byte,
    output logic               tm_valid, // tm_len holds a finished scl phase
    output logic [15:0]        tm_len
);
    timeunit 1ns;
    timeprecision 1ps;

    logic               p_scl;  // levels seen at the previous edge
    logic               p_sda;
    logic [3:0]         bitn;   // bits seen in the current frame
    logic               hi_chk; // scl high phase of a data bit in progress
    logic [15:0]        cnt;    // edges since the last scl change
    i2c_seq_pkg::byte_t sh;

    always @(posedge mclk) begin
        ev_valid <= 1'b0;
        tm_valid <= 1'b0;
        p_scl    <= scl;
        p_sda    <= sda;
        if (flush) begin
            bitn   <= '0;
            hi_chk <= 1'b0;
            cnt    <= 16'd1;
        end else begin
            cnt <= (scl != p_scl) ? 16'd1 : cnt + 1'b1;
            if (p_scl && scl && p_sda && !sda) begin          // start
                ev_valid <= 1'b1;
                ev_kind  <= 2'd0;
                bitn     <= '0;
                hi_chk   <= 1'b0;
            end else if (p_scl && scl && !p_sda && sda) begin // stop
                ev_valid <= 1'b1;
                ev_kind  <= 2'd2;
                bitn     <= '0;
                hi_chk   <= 1'b0;
            end else if (!p_scl && scl) begin
                sh     <= {sh[6:0], sda};                     // sample on the rising edge
                hi_chk <= 1'b1;
                if (bitn != 4'd0) begin                       // low phase inside the frame
                    tm_valid <= 1'b1;
                    tm_len   <= cnt;
                end
                if (bitn == 4'd8) begin                       // ack bit closes the byte
                    ev_valid <= 1'b1;
                    ev_kind  <= 2'd1;
                    ev_byte  <= sh;
                    bitn     <= '0;
                end else begin
                    bitn <= bitn + 1'b1;
                end
            end else if (p_scl && !scl && hi_chk) begin
                tm_valid <= 1'b1;                             // high phase of a data bit
                tm_len   <= cnt;
                hi_chk   <= 1'b0;
            end
        end
    end

endmodule

//--- verification/i2c_seq_tb.sv
/*
 * Testbench for the i2c register-write sequencer.
 * Loads random table entries, runs random command words against a model of
 * the expected bus events, checks flags, bit timing and an abort mid-command.
 * Run through the Makefile, the log decides pass or fail.
 */
module i2c_seq_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                             mclk, mrst, i2c_rst, i2c_start, tand, twe;
    logic [i2c_seq_pkg::TD_W-1:0]     td;
    logic [i2c_seq_pkg::SEQ_RA_W-1:0] seq_mem_ra;
    logic [1:0]                       seq_mem_re;
    i2c_seq_pkg::byte_t               seq_rd;
    logic                             scl, sda_en, i2c_run, i2c_busy;

    logic                    flush, ev_valid, tm_valid, re_q;
    logic [1:0]              ev_kind;
    logic [15:0]             tm_len;
    logic [1:0]              ra_q;
    logic [31:0]             seed = 32'hdb7c;
    i2c_seq_pkg::byte_t      ev_byte, base;
    i2c_seq_pkg::byte_t      word [4];           // current command word
    i2c_seq_pkg::tbl_entry_t shadow [256];       // table model
    i2c_seq_pkg::dly_t       cur_dly;
    logic [1:0]              got_k [$], exp_k [$];
    i2c_seq_pkg::byte_t      got_b [$], exp_b [$];

    i2c_seq_top #(.TBL_ADDR_BITS (8)) DUT (.*);

    i2c_slave_mon i_mon (
        .mclk (mclk), .flush (flush), .scl (scl), .sda (!sda_en),
        .ev_valid (ev_valid), .ev_kind (ev_kind), .ev_byte (ev_byte),
        .tm_valid (tm_valid), .tm_len (tm_len)
    );

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'd0, seed[30:15]};             // upper bits, low ones cycle fast
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input i2c_seq_pkg::byte_t got, exp);
        if (got !== exp) fail_run($sformatf("mismatch %s got %h exp %h", name, got, exp));
    endtask

    task automatic check_event(input string name, input logic [1:0] got, exp);
        if (got !== exp) fail_run($sformatf("mismatch %s got %h exp %h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, exp);
        if (got !== exp) fail_run($sformatf("mismatch %s got %h exp %h", name, got, exp));
    endtask

    task automatic check_len(input string name, input logic [15:0] got, exp);
        if (got !== exp) fail_run($sformatf("mismatch %s got %h exp %h", name, got, exp));
    endtask

    // sequencer memory, data two cycles after the strobe
    always @(posedge mclk) begin
        if (!flush) check_level("seq_mem_re[1]", seq_mem_re[1], re_q); // regen follows re
        re_q <= seq_mem_re[0];
        if (seq_mem_re[0]) ra_q <= seq_mem_ra;
        if (re_q) seq_rd <= word[ra_q];
    end

    always @(posedge mclk) begin
        if (ev_valid) begin
            got_k.push_back(ev_kind);
            got_b.push_back(ev_byte);
        end
        if (tm_valid) check_len("scl phase", tm_len, {7'd0, cur_dly, 1'b0} + 16'd2);
        if (!mrst && i2c_run && !i2c_busy) fail_run("i2c_run is high while i2c_busy is low");
    end

    task automatic load_table(input i2c_seq_pkg::byte_t start, input int n);
        i2c_seq_pkg::tbl_entry_t e;
        @(posedge mclk);
        twe  <= 1'b1;
        tand <= 1'b1;
        td   <= {20'd0, start};
        for (int i = 0; i < n; i++) begin
            e.sa   = 7'(next_rand());
            e.nbwr = 4'd1 + 4'(next_rand() % 4);
            e.dly  = 8'd1 + 8'(next_rand() % 4);
            e.rsvd = 1'(next_rand());
            e.rah  = 8'(next_rand());
            shadow[8'(start + i)] = e;
            @(posedge mclk);
            tand <= 1'b0;
            td   <= e;
        end
        @(posedge mclk);
        twe <= 1'b0;
    endtask

    // sets the word, builds the expected events and pulses i2c_start
    task automatic start_cmd(input i2c_seq_pkg::byte_t idx);
        i2c_seq_pkg::tbl_entry_t e;
        e = shadow[idx];
        word[3] = idx;
        for (int i = 0; i < 3; i++) word[i] = 8'(next_rand());
        cur_dly = e.dly;
        got_k.delete();
        got_b.delete();
        exp_k.delete();
        exp_b.delete();
        exp_k.push_back(2'd0);
        exp_b.push_back(8'h00);
        exp_k.push_back(2'd1);
        exp_b.push_back({e.sa, 1'b0});         // write address
        if (e.nbwr == 4'd4) begin
            exp_k.push_back(2'd1);
            exp_b.push_back(e.rah);
        end
        for (int i = (e.nbwr > 3 ? 3 : int'(e.nbwr)) - 1; i >= 0; i--) begin
            exp_k.push_back(2'd1);
            exp_b.push_back(word[i]);
        end
        exp_k.push_back(2'd2);
        exp_b.push_back(8'h00);
        @(posedge mclk);
        i2c_start <= 1'b1;
        @(posedge mclk);
        i2c_start <= 1'b0;
        @(posedge mclk);
        check_level("i2c_run", i2c_run, 1'b1);
        check_level("i2c_busy", i2c_busy, 1'b1);
    endtask

    task automatic finish_cmd();
        int t;
        t = 0;
        while (i2c_busy) begin
            @(posedge mclk);
            t++;
            if (t > 20000) fail_run("timeout waiting for i2c_busy to fall");
        end
        @(posedge mclk);                         // last event reaches the queue
        if (got_k.size() != exp_k.size()) fail_run("wrong number of bus events");
        for (int i = 0; i < exp_k.size(); i++) begin
            check_event("bus event", got_k[i], exp_k[i]);
            if (exp_k[i] == 2'd1) check_byte("bus byte", got_b[i], exp_b[i]);
        end
    endtask

    initial begin
        mrst      = 1'b1;
        i2c_rst   = 1'b0;
        i2c_start = 1'b0;
        tand      = 1'b0;
        twe       = 1'b0;
        td        = '0;
        seq_rd    = '0;
        flush     = 1'b1;
        cur_dly   = 8'd1;
        repeat (5) @(posedge mclk);
        mrst <= 1'b0;
        @(posedge mclk);
        flush <= 1'b0;
        @(posedge mclk);
        check_level("i2c_run", i2c_run, 1'b0);
        check_level("i2c_busy", i2c_busy, 1'b0);
        check_level("scl", scl, 1'b1);
        base = 8'(next_rand());
        load_table(base, 8);
        for (int i = 0; i < 8; i++) begin     // every loaded entry once
            start_cmd(8'(base + i));
            finish_cmd();
        end
        for (int i = 0; i < 6; i++) begin
            start_cmd(8'(base + next_rand() % 8));
            finish_cmd();
        end
        start_cmd(8'(base + next_rand() % 8));
        repeat (20 + next_rand() % 120) @(posedge mclk); // shorter than any command
        check_level("i2c_busy", i2c_busy, 1'b1);
        i2c_rst <= 1'b1;
        flush   <= 1'b1;
        @(posedge mclk);
        i2c_rst <= 1'b0;
        @(posedge mclk);
        check_level("scl", scl, 1'b1);
        check_level("sda_en", sda_en, 1'b0);
        check_level("i2c_run", i2c_run, 1'b0);
        check_level("i2c_busy", i2c_busy, 1'b0);
        @(posedge mclk);
        flush <= 1'b0;
        start_cmd(8'(base + next_rand() % 8));
        finish_cmd();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- i2c_seq.f
source/i2c_seq_pkg.sv
source/i2c_bit_if.sv
source/i2c_xlat_table.sv
source/i2c_cmd_seq.sv
source/i2c_bit_engine.sv
source/i2c_seq_top.sv
verification/i2c_slave_mon.sv
verification/i2c_seq_tb.sv

//--- Makefile
# Verilator build and run of the i2c_seq testbench

VERILATOR ?= verilator
TOP       ?= i2c_seq_tb
FILELIST  ?= i2c_seq.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(wildcard source/*.sv) $(wildcard verification/*.sv)
BIN  := $(BUILD)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
